// File: list.f
src/aluRsPkg.sv
src/allocIf.sv
src/issueIf.sv
src/instDecode.sv
src/rsLine.sv
src/aluRs.sv
src/aluExec.sv
src/resultBus.sv
src/aluCluster.sv
sim/aluCluster_chk.sv
sim/tbAluCluster.sv

// File: sim/tbAluCluster.sv
module tbAluCluster;

    // six short tests, each well under a few hundred cycles
    localparam int timeoutCycles = 2000;
    localparam int numTags = 1 << aluRsPkg::tagWidth;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic dispValid;
    logic dispReady;
    aluRsPkg::instWord_t dispInst;
    logic [aluRsPkg::dataWidth-1:0] dispValA;
    logic [aluRsPkg::tagWidth-1:0] dispTagA;
    logic [aluRsPkg::dataWidth-1:0] dispValB;
    logic [aluRsPkg::tagWidth-1:0] dispTagB;
    logic [aluRsPkg::tagWidth-1:0] dispDestTag;
    logic lsValid;
    logic lsReady;
    logic [aluRsPkg::tagWidth-1:0] lsTag;
    logic [aluRsPkg::dataWidth-1:0] lsData;
    logic cdbValid;
    logic [aluRsPkg::tagWidth-1:0] cdbTag;
    logic [aluRsPkg::dataWidth-1:0] cdbData;

    // expected broadcasts, indexed by tag
    logic [aluRsPkg::dataWidth-1:0] expData [numTags];
    bit expPending [numTags];
    int arrival [numTags];
    int pending = 0;
    int seqNo = 0;
    int errors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycles = 0;

    logic [2:0] regFunct3 [8] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5};

    aluCluster dut (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .dispValid(dispValid),
        .dispReady(dispReady),
        .dispInst(dispInst),
        .dispValA(dispValA),
        .dispTagA(dispTagA),
        .dispValB(dispValB),
        .dispTagB(dispTagB),
        .dispDestTag(dispDestTag),
        .lsValid(lsValid),
        .lsReady(lsReady),
        .lsTag(lsTag),
        .lsData(lsData),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("timeout: run stopped after %0d cycles, %0d results outstanding",
                     cycles, pending);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic aluRsPkg::instWord_t makeR(input logic [6:0] funct7,
                                                  input logic [2:0] funct3);
        aluRsPkg::instWord_t w;
        w.rType.funct7 = funct7;
        w.rType.rs2 = 5'd2;
        w.rType.rs1 = 5'd1;
        w.rType.funct3 = funct3;
        w.rType.rd = 5'd3;
        w.rType.opcode = aluRsPkg::opcodeOp;
        return w;
    endfunction

    function automatic aluRsPkg::instWord_t makeI(input logic [2:0] funct3,
                                                  input logic [11:0] imm12);
        aluRsPkg::instWord_t w;
        w.iType.imm12 = imm12;
        w.iType.rs1 = 5'd1;
        w.iType.funct3 = funct3;
        w.iType.rd = 5'd3;
        w.iType.opcode = aluRsPkg::opcodeOpImm;
        return w;
    endfunction

    function automatic bit isAluWord(input aluRsPkg::instWord_t w);
        bit isR;
        bit isI;
        isR = w.rType.opcode == aluRsPkg::opcodeOp;
        isI = w.iType.opcode == aluRsPkg::opcodeOpImm;
        if (!(isR || isI) || w.rType.funct3 == 3'd3) begin
            return 1'b0;
        end
        // SRA and the other funct7 variants are not part of this cluster
        return !(isR && w.rType.funct7[5] && w.rType.funct3 != 3'd0);
    endfunction

    // RV32I integer rules
    function automatic logic [31:0] refResult(input aluRsPkg::instWord_t w,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] rhs;
        logic sub;
        rhs = b;
        sub = w.rType.funct7[5];
        if (w.iType.opcode == aluRsPkg::opcodeOpImm) begin
            rhs = {{20{w.iType.imm12[11]}}, w.iType.imm12};
            sub = 1'b0;
        end
        case (w.rType.funct3)
            3'd0: return sub ? a - rhs : a + rhs;
            3'd1: return a << rhs[4:0];
            3'd2: return ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
            3'd4: return a ^ rhs;
            3'd5: return a >> rhs[4:0];
            3'd6: return a | rhs;
            3'd7: return a & rhs;
            default: return '0;
        endcase
    endfunction

    task automatic recordResult(input logic [aluRsPkg::tagWidth-1:0] tag,
                                input logic [aluRsPkg::dataWidth-1:0] data);
        if (expPending[tag]) begin
            errors++;
            $display("tag %0d reused while its result is still in flight", tag);
        end
        expPending[tag] = 1'b1;
        expData[tag] = data;
        pending++;
    endtask

    task automatic checkCdb(input logic [aluRsPkg::tagWidth-1:0] tag,
                            input logic [aluRsPkg::dataWidth-1:0] data);
        if (!expPending[tag]) begin
            errors++;
            $display("unexpected broadcast on tag %0d with data %h", tag, data);
        end else begin
            if (data !== expData[tag]) begin
                errors++;
                $display("[ERROR] cdbData tag %h: got %h, expected %h",
                         tag, data, expData[tag]);
            end
            expPending[tag] = 1'b0;
            pending--;
            seqNo++;
            arrival[tag] = seqNo;
        end
    endtask

    task automatic checkReady(input logic expected);
        if (dispReady !== expected) begin
            errors++;
            $display("[ERROR] dispReady: got %h, expected %h", dispReady, expected);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst && cdbValid) begin
            checkCdb(cdbTag, cdbData);
        end
    end

    task automatic dispatch(input aluRsPkg::instWord_t w,
                            input logic [31:0] a,
                            input logic [aluRsPkg::tagWidth-1:0] tagA,
                            input logic [31:0] b,
                            input logic [aluRsPkg::tagWidth-1:0] tagB,
                            input logic [aluRsPkg::tagWidth-1:0] dest,
                            input bit track);
        logic seen;
        dispValid = 1'b1;
        dispInst = w;
        dispValA = (tagA != aluRsPkg::tagFree) ? $urandom() : a;
        dispTagA = tagA;
        dispValB = (tagB != aluRsPkg::tagFree) ? $urandom() : b;
        dispTagB = tagB;
        dispDestTag = dest;
        if (track && isAluWord(w)) begin
            recordResult(dest, refResult(w, a, b));
        end
        do begin
            @(negedge clk);
            seen = dispReady;
            @(posedge clk);
            #1;
        end while (!seen);
        dispValid = 1'b0;
    endtask

    // leaves lsValid high so that calls can run back to back
    task automatic lsSend(input logic [aluRsPkg::tagWidth-1:0] tag,
                          input logic [aluRsPkg::dataWidth-1:0] data);
        logic seen;
        lsValid = 1'b1;
        lsTag = tag;
        lsData = data;
        recordResult(tag, data);
        do begin
            @(negedge clk);
            seen = lsReady;
            @(posedge clk);
            #1;
        end while (!seen);
    endtask

    task automatic waitDrain();
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic testRegOps();
        int e;
        e = errors;
        for (int i = 0; i < 8; i++) begin
            dispatch(makeR((i == 1) ? 7'h20 : 7'h00, regFunct3[i]), $urandom(),
                     aluRsPkg::tagFree, $urandom(), aluRsPkg::tagFree, 4'(i + 1), 1'b1);
        end
        waitDrain();
        finishTest("register ops", e);
    endtask

    task automatic testImmOps();
        int e;
        aluRsPkg::instWord_t bad;
        e = errors;
        dispatch(makeI(3'd0, 12'hF9C), $urandom(), 0, 0, 0, 4'd1, 1'b1);
        dispatch(makeI(3'd7, 12'h8F0), $urandom(), 0, 0, 0, 4'd2, 1'b1);
        dispatch(makeI(3'd6, 12'h0F0), $urandom(), 0, 0, 0, 4'd3, 1'b1);
        dispatch(makeI(3'd4, 12'hFFF), $urandom(), 0, 0, 0, 4'd4, 1'b1);
        dispatch(makeI(3'd2, 12'hFFF), 32'hFFFF_FFFB, 0, 0, 0, 4'd5, 1'b1);
        dispatch(makeI(3'd2, 12'h800), $urandom(), 0, 0, 0, 4'd6, 1'b1);
        dispatch(makeI(3'd1, 12'h007), $urandom(), 0, 0, 0, 4'd7, 1'b1);
        dispatch(makeI(3'd5, 12'h00D), $urandom(), 0, 0, 0, 4'd8, 1'b1);
        // a load word is consumed without a result
        bad = makeI(3'd2, 12'h004);
        bad.iType.opcode = 7'b0000011;
        dispatch(bad, $urandom(), 0, 0, 0, 4'd9, 1'b1);
        waitDrain();
        idleCycles(8);
        finishTest("immediate ops", e);
    endtask

    task automatic testWakeup();
        int e;
        logic [31:0] a;
        logic [31:0] b;
        e = errors;
        a = $urandom();
        b = $urandom();
        dispatch(makeR(7'h00, 3'd4), a, aluRsPkg::tagFree, b, 4'd10, 4'd1, 1'b1);
        idleCycles(5);
        if (!expPending[1]) begin
            errors++;
            $display("result on tag 1 arrived before its operand was broadcast");
        end
        lsSend(4'd10, b);
        lsValid = 1'b0;
        waitDrain();
        // producer broadcast lands on the dispatch edge
        a = $urandom();
        b = $urandom();
        lsSend(4'd11, a);
        lsValid = 1'b0;
        dispatch(makeR(7'h20, 3'd0), a, 4'd11, b, aluRsPkg::tagFree, 4'd2, 1'b1);
        waitDrain();
        finishTest("operand wake-up", e);
    endtask

    task automatic testContention();
        int e;
        int lastLs;
        int firstAlu;
        e = errors;
        fork
            begin
                for (int t = 8; t < 16; t++) begin
                    lsSend(4'(t), $urandom());
                end
                lsValid = 1'b0;
            end
            begin
                idleCycles(1);
                for (int i = 1; i <= 3; i++) begin
                    dispatch(makeR(7'h00, 3'd0), $urandom(), aluRsPkg::tagFree,
                             $urandom(), aluRsPkg::tagFree, 4'(i), 1'b1);
                end
            end
        join
        waitDrain();
        lastLs = 0;
        firstAlu = seqNo + 1;
        for (int t = 8; t < 16; t++) begin
            lastLs = (arrival[t] > lastLs) ? arrival[t] : lastLs;
        end
        for (int t = 1; t <= 3; t++) begin
            firstAlu = (arrival[t] < firstAlu) ? arrival[t] : firstAlu;
        end
        if (firstAlu < lastLs) begin
            errors++;
            $display("an ALU result was broadcast before the load/store stream ended");
        end
        finishTest("result bus contention", e);
    endtask

    task automatic testFullStation();
        int e;
        bit rose;
        logic [31:0] srcA [4];
        e = errors;
        for (int i = 0; i < 4; i++) begin
            srcA[i] = $urandom();
            dispatch(makeR(7'h00, 3'd6), srcA[i], 4'(11 + i), $urandom(),
                     aluRsPkg::tagFree, 4'(i + 1), 1'b1);
        end
        @(negedge clk);
        checkReady(1'b0);
        @(posedge clk);
        #1;
        lsSend(4'd11, srcA[0]);
        lsValid = 1'b0;
        rose = 1'b0;
        for (int c = 0; c < 10 && !rose; c++) begin
            @(negedge clk);
            rose = dispReady;
        end
        if (!rose) begin
            errors++;
            $display("dispReady stayed low after a waiting line was woken");
        end
        @(posedge clk);
        #1;
        for (int t = 12; t < 15; t++) begin
            lsSend(4'(t), srcA[t - 11]);
        end
        lsValid = 1'b0;
        waitDrain();
        finishTest("full station", e);
    endtask

    task automatic testFlush();
        int e;
        e = errors;
        // fill every line with an op waiting on tag 7 or 8
        for (int i = 0; i < 4; i++) begin
            dispatch(makeR(7'h00, 3'd7), $urandom(), (i < 2) ? 4'd7 : 4'd8, $urandom(),
                     aluRsPkg::tagFree, 4'(i + 1), 1'b0);
        end
        @(negedge clk);
        checkReady(1'b0);
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        checkReady(1'b1);
        @(posedge clk);
        #1;
        // wake-ups for the discarded lines must find nothing
        lsSend(4'd7, $urandom());
        lsSend(4'd8, $urandom());
        lsValid = 1'b0;
        waitDrain();
        idleCycles(8);
        finishTest("flush", e);
    endtask

    initial begin
        int total;
        void'($urandom(23101));
        rst = 1'b1;
        flush = 1'b0;
        dispValid = 1'b0;
        dispInst = '0;
        dispValA = '0;
        dispTagA = '0;
        dispValB = '0;
        dispTagB = '0;
        dispDestTag = '0;
        lsValid = 1'b0;
        lsTag = '0;
        lsData = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkReady(1'b1);
        @(posedge clk);
        #1;
        testRegOps();
        testImmOps();
        testWakeup();
        testContention();
        testFullStation();
        testFlush();
        total = errors + dut.uRs.chk.assertFails;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, dut.uRs.chk.assertFails);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/aluCluster_chk.sv
module aluCluster_chk (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic [aluRsPkg::rsSize-1:0] lineEmpty,
    input logic [aluRsPkg::rsSize-1:0] lineReady,
    input logic [aluRsPkg::rsSize-1:0] allocEn,
    input logic [aluRsPkg::rsSize-1:0] issueEn
);

    int assertFails = 0;

    // a ready line stays on offer until the ALU takes it
    issueHeld: assert property (@(posedge clk) disable iff (rst)
        (|lineReady) && !(|issueEn) && !flush |=> |lineReady)
        else begin
            assertFails++;
            $error("issue valid dropped before the ALU accepted it");
        end

    // an accepted allocation leaves its line busy
    allocFillsLine: assert property (@(posedge clk) disable iff (rst)
        (|allocEn) && !flush |=> (lineEmpty & $past(allocEn)) == '0)
        else begin
            assertFails++;
            $error("allocated line still empty after the allocating edge");
        end

    // the issued line is free again after the issue edge
    issueFreesLine: assert property (@(posedge clk) disable iff (rst)
        (|issueEn) |=> (lineEmpty & $past(issueEn)) == $past(issueEn))
        else begin
            assertFails++;
            $error("issued line still busy after the issue edge");
        end

endmodule

bind aluRs aluCluster_chk chk (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .lineEmpty(lineEmpty),
    .lineReady(lineReady),
    .allocEn(allocEn),
    .issueEn(issueEn)
);

// File: src/aluCluster.sv
module aluCluster (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic dispValid,
    output logic dispReady,
    input  aluRsPkg::instWord_t dispInst,
    input  logic [aluRsPkg::dataWidth-1:0] dispValA,
    input  logic [aluRsPkg::tagWidth-1:0] dispTagA,
    input  logic [aluRsPkg::dataWidth-1:0] dispValB,
    input  logic [aluRsPkg::tagWidth-1:0] dispTagB,
    input  logic [aluRsPkg::tagWidth-1:0] dispDestTag,
    input  logic lsValid,
    output logic lsReady,
    input  logic [aluRsPkg::tagWidth-1:0] lsTag,
    input  logic [aluRsPkg::dataWidth-1:0] lsData,
    output logic cdbValid,
    output logic [aluRsPkg::tagWidth-1:0] cdbTag,
    output logic [aluRsPkg::dataWidth-1:0] cdbData
);

    allocIf alloc ();
    issueIf issue ();

    logic resValid;
    logic resReady;
    logic [aluRsPkg::tagWidth-1:0] resTag;
    logic [aluRsPkg::dataWidth-1:0] resData;

    instDecode uDecode (
        .dispValid(dispValid),
        .dispReady(dispReady),
        .dispInst(dispInst),
        .dispValA(dispValA),
        .dispValB(dispValB),
        .dispTagA(dispTagA),
        .dispTagB(dispTagB),
        .dispDestTag(dispDestTag),
        .alloc(alloc.dec)
    );

    aluRs uRs (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .alloc(alloc.rs),
        .issue(issue.rs),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData)
    );

    aluExec uExec (
        .clk(clk),
        .rst(rst),
        .issue(issue.alu),
        .resValid(resValid),
        .resReady(resReady),
        .resTag(resTag),
        .resData(resData)
    );

    // broadcast also feeds the station wake-up
    resultBus uBus (
        .clk(clk),
        .rst(rst),
        .lsValid(lsValid),
        .lsReady(lsReady),
        .lsTag(lsTag),
        .lsData(lsData),
        .resValid(resValid),
        .resReady(resReady),
        .resTag(resTag),
        .resData(resData),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData)
    );

endmodule

// File: src/resultBus.sv
module resultBus (
    input  logic clk,
    input  logic rst,
    input  logic lsValid,
    output logic lsReady,
    input  logic [aluRsPkg::tagWidth-1:0] lsTag,
    input  logic [aluRsPkg::dataWidth-1:0] lsData,
    input  logic resValid,
    output logic resReady,
    input  logic [aluRsPkg::tagWidth-1:0] resTag,
    input  logic [aluRsPkg::dataWidth-1:0] resData,
    output logic cdbValid,
    output logic [aluRsPkg::tagWidth-1:0] cdbTag,
    output logic [aluRsPkg::dataWidth-1:0] cdbData
);

    // load/store always wins, ALU only gets idle slots
    assign lsReady = 1'b1;
    assign resReady = !lsValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdbValid <= 1'b0;
        end else begin
            cdbValid <= lsValid || resValid;
        end
    end

    always_ff @(posedge clk) begin
        if (lsValid) begin
            cdbTag <= lsTag;
            cdbData <= lsData;
        end else if (resValid) begin
            cdbTag <= resTag;
            cdbData <= resData;
        end
    end

endmodule

// File: src/aluExec.sv
module aluExec (
    input  logic clk,
    input  logic rst,
    issueIf.alu issue,
    output logic resValid,
    input  logic resReady,
    output logic [aluRsPkg::tagWidth-1:0] resTag,
    output logic [aluRsPkg::dataWidth-1:0] resData
);

    logic [aluRsPkg::dataWidth-1:0] result;
    logic take;

    always_comb begin
        case (issue.op)
            aluRsPkg::aluAdd: result = issue.opA + issue.opB;
            aluRsPkg::aluSub: result = issue.opA - issue.opB;
            aluRsPkg::aluAnd: result = issue.opA & issue.opB;
            aluRsPkg::aluOr:  result = issue.opA | issue.opB;
            aluRsPkg::aluXor: result = issue.opA ^ issue.opB;
            aluRsPkg::aluSlt: result = {{(aluRsPkg::dataWidth - 1){1'b0}},
                                        $signed(issue.opA) < $signed(issue.opB)};
            aluRsPkg::aluSll: result = issue.opA << issue.opB[4:0];
            aluRsPkg::aluSrl: result = issue.opA >> issue.opB[4:0];
            default:          result = '0;
        endcase
    end

    // free slot, or the held result leaves this cycle
    assign issue.ready = !resValid || resReady;
    assign take = issue.valid && issue.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else if (take) begin
            resValid <= 1'b1;
        end else if (resReady) begin
            resValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resTag <= issue.destTag;
            resData <= result;
        end
    end

endmodule

// File: src/aluRs.sv
module aluRs (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    allocIf.rs alloc,
    issueIf.rs issue,
    input  logic cdbValid,
    input  logic [aluRsPkg::tagWidth-1:0] cdbTag,
    input  logic [aluRsPkg::dataWidth-1:0] cdbData
);

    logic [aluRsPkg::rsSize-1:0] lineEmpty;
    logic [aluRsPkg::rsSize-1:0] lineReady;
    logic [aluRsPkg::rsSize-1:0] allocSel;
    logic [aluRsPkg::rsSize-1:0] issueSel;
    logic [aluRsPkg::rsSize-1:0] allocEn;
    logic [aluRsPkg::rsSize-1:0] issueEn;
    logic [aluRsPkg::dataWidth-1:0] lineOpA [aluRsPkg::rsSize];
    logic [aluRsPkg::dataWidth-1:0] lineOpB [aluRsPkg::rsSize];
    aluRsPkg::aluOp_t lineOp [aluRsPkg::rsSize];
    logic [aluRsPkg::tagWidth-1:0] lineDest [aluRsPkg::rsSize];

    for (genvar i = 0; i < aluRsPkg::rsSize; i++) begin : gLine
        rsLine line (
            .clk(clk),
            .rst(rst),
            .flush(flush),
            .allocEn(allocEn[i]),
            .allocOp(alloc.op),
            .allocValA(alloc.valA),
            .allocTagA(alloc.tagA),
            .allocValB(alloc.valB),
            .allocTagB(alloc.tagB),
            .allocDestTag(alloc.destTag),
            .cdbValid(cdbValid),
            .cdbTag(cdbTag),
            .cdbData(cdbData),
            .empty(lineEmpty[i]),
            .ready(lineReady[i]),
            .opA(lineOpA[i]),
            .opB(lineOpB[i]),
            .op(lineOp[i]),
            .destTag(lineDest[i]),
            .issueEn(issueEn[i])
        );
    end

    // scan downward so the lowest index wins
    always_comb begin
        allocSel = '0;
        issueSel = '0;
        issue.op = aluRsPkg::aluAdd;
        issue.opA = '0;
        issue.opB = '0;
        issue.destTag = aluRsPkg::tagFree;
        for (int i = aluRsPkg::rsSize - 1; i >= 0; i--) begin
            if (lineEmpty[i]) begin
                allocSel = '0;
                allocSel[i] = 1'b1;
            end
            if (lineReady[i]) begin
                issueSel = '0;
                issueSel[i] = 1'b1;
                issue.op = lineOp[i];
                issue.opA = lineOpA[i];
                issue.opB = lineOpB[i];
                issue.destTag = lineDest[i];
            end
        end
    end

    assign alloc.ready = |lineEmpty;
    assign issue.valid = |lineReady;

    assign allocEn = allocSel & {aluRsPkg::rsSize{alloc.valid && alloc.ready}};
    assign issueEn = issueSel & {aluRsPkg::rsSize{issue.valid && issue.ready}};

endmodule

// File: src/rsLine.sv
module rsLine (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic allocEn,
    input  aluRsPkg::aluOp_t allocOp,
    input  logic [aluRsPkg::dataWidth-1:0] allocValA,
    input  logic [aluRsPkg::tagWidth-1:0] allocTagA,
    input  logic [aluRsPkg::dataWidth-1:0] allocValB,
    input  logic [aluRsPkg::tagWidth-1:0] allocTagB,
    input  logic [aluRsPkg::tagWidth-1:0] allocDestTag,
    input  logic cdbValid,
    input  logic [aluRsPkg::tagWidth-1:0] cdbTag,
    input  logic [aluRsPkg::dataWidth-1:0] cdbData,
    output logic empty,
    output logic ready,
    output logic [aluRsPkg::dataWidth-1:0] opA,
    output logic [aluRsPkg::dataWidth-1:0] opB,
    output aluRsPkg::aluOp_t op,
    output logic [aluRsPkg::tagWidth-1:0] destTag,
    input  logic issueEn
);

    logic busy;
    logic [aluRsPkg::tagWidth-1:0] tagA;
    logic [aluRsPkg::tagWidth-1:0] tagB;
    logic [aluRsPkg::tagWidth-1:0] srcTagA;
    logic [aluRsPkg::tagWidth-1:0] srcTagB;
    logic hitA;
    logic hitB;

    // snoop the incoming pair on the allocating edge, else the held one
    assign srcTagA = allocEn ? allocTagA : tagA;
    assign srcTagB = allocEn ? allocTagB : tagB;

    assign hitA = cdbValid && (srcTagA != aluRsPkg::tagFree) && (srcTagA == cdbTag);
    assign hitB = cdbValid && (srcTagB != aluRsPkg::tagFree) && (srcTagB == cdbTag);

    always_ff @(posedge clk) begin
        if (rst || flush || issueEn) begin
            busy <= 1'b0;
        end else if (allocEn) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            op <= allocOp;
            destTag <= allocDestTag;
        end
        tagA <= hitA ? aluRsPkg::tagFree : srcTagA;
        tagB <= hitB ? aluRsPkg::tagFree : srcTagB;
        if (hitA) begin
            opA <= cdbData;
        end else if (allocEn) begin
            opA <= allocValA;
        end
        if (hitB) begin
            opB <= cdbData;
        end else if (allocEn) begin
            opB <= allocValB;
        end
    end

    assign empty = !busy;
    assign ready = busy && (tagA == aluRsPkg::tagFree) && (tagB == aluRsPkg::tagFree);

endmodule

// File: src/instDecode.sv
module instDecode (
    input  logic dispValid,
    output logic dispReady,
    input  aluRsPkg::instWord_t dispInst,
    input  logic [aluRsPkg::dataWidth-1:0] dispValA,
    input  logic [aluRsPkg::dataWidth-1:0] dispValB,
    input  logic [aluRsPkg::tagWidth-1:0] dispTagA,
    input  logic [aluRsPkg::tagWidth-1:0] dispTagB,
    input  logic [aluRsPkg::tagWidth-1:0] dispDestTag,
    allocIf.dec alloc
);

    logic isOp;
    logic isOpImm;
    logic known;
    logic [3:0] opKey;

    assign isOp = dispInst.rType.opcode == aluRsPkg::opcodeOp;
    assign isOpImm = dispInst.iType.opcode == aluRsPkg::opcodeOpImm;

    // funct7 bit 5 only splits ADD and SUB for register ops
    assign opKey = isOp ? {dispInst.rType.funct7[5], dispInst.rType.funct3}
                        : {1'b0, dispInst.iType.funct3};

    always_comb begin
        known = isOp || isOpImm;
        alloc.op = aluRsPkg::aluAdd;
        case (opKey)
            4'b0000: alloc.op = aluRsPkg::aluAdd;
            4'b1000: alloc.op = aluRsPkg::aluSub;
            4'b0001: alloc.op = aluRsPkg::aluSll;
            4'b0010: alloc.op = aluRsPkg::aluSlt;
            4'b0100: alloc.op = aluRsPkg::aluXor;
            4'b0101: alloc.op = aluRsPkg::aluSrl;
            4'b0110: alloc.op = aluRsPkg::aluOr;
            4'b0111: alloc.op = aluRsPkg::aluAnd;
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        alloc.valB = dispValB;
        alloc.tagB = dispTagB;
        if (isOpImm) begin
            alloc.valB = {{(aluRsPkg::dataWidth - 12){dispInst.iType.imm12[11]}},
                          dispInst.iType.imm12};
            alloc.tagB = aluRsPkg::tagFree;
        end
    end

    // unsupported words are consumed but never reach the station
    assign alloc.valid = dispValid && known;
    assign alloc.valA = dispValA;
    assign alloc.tagA = dispTagA;
    assign alloc.destTag = dispDestTag;
    assign dispReady = alloc.ready;

endmodule

// File: src/issueIf.sv
interface issueIf;

    logic valid;
    logic ready;
    aluRsPkg::aluOp_t op;
    logic [aluRsPkg::dataWidth-1:0] opA;
    logic [aluRsPkg::dataWidth-1:0] opB;
    logic [aluRsPkg::tagWidth-1:0] destTag;

    modport rs (
        output valid, op, opA, opB, destTag,
        input  ready
    );

    modport alu (
        input  valid, op, opA, opB, destTag,
        output ready
    );

endinterface

// File: src/allocIf.sv
interface allocIf;

    logic valid;
    logic ready;
    aluRsPkg::aluOp_t op;
    logic [aluRsPkg::dataWidth-1:0] valA;
    logic [aluRsPkg::tagWidth-1:0] tagA;
    logic [aluRsPkg::dataWidth-1:0] valB;
    logic [aluRsPkg::tagWidth-1:0] tagB;
    logic [aluRsPkg::tagWidth-1:0] destTag;

    modport dec (
        output valid, op, valA, tagA, valB, tagB, destTag,
        input  ready
    );

    modport rs (
        input  valid, op, valA, tagA, valB, tagB, destTag,
        output ready
    );

endinterface

// File: src/aluRsPkg.sv
package aluRsPkg;

    localparam int dataWidth = 32;
    localparam int tagWidth = 4;
    localparam int rsSize = 4;
    localparam int opWidth = 4;

    // tag zero means the value is already present
    localparam logic [tagWidth-1:0] tagFree = '0;

    localparam logic [6:0] opcodeOp = 7'b0110011;
    localparam logic [6:0] opcodeOpImm = 7'b0010011;

    typedef enum logic [opWidth-1:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl
    } aluOp_t;

    // same 32 bits seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } iType;
    } instWord_t;

endpackage
